// File: sched_consts.svh
//////////////////////////////
// Egress scheduler constants
// Queue counts, widths, word size and depths
//////////////////////////////

`ifndef SCHED_CONSTS_SVH
`define SCHED_CONSTS_SVH

// Queue layout
`define SCHED_NUM_PORTS        4
`define SCHED_CLASSES_PER_PORT 4
`define SCHED_NUM_QUEUES       16

// Field widths
`define SCHED_PORT_W           2
`define SCHED_CLASS_W          2
`define SCHED_QUEUE_W          4
`define SCHED_BLEN_W           11
`define SCHED_BYTES_W          7

// Datapath word and storage depths
`define SCHED_WORD_BYTES       64
`define SCHED_FIFO_DEPTH       8
`define SCHED_BUF_WORDS        4
`define SCHED_REQ_PIPE         2

`endif

// File: sched_pkg.sv
//////////////////////////////
// Egress scheduler types
//////////////////////////////

`default_nettype none

`include "sched_consts.svh"

package sched_pkg;

    // Upper bits are the port, lower bits the class
    typedef logic [`SCHED_QUEUE_W-1:0] queue_id_t;

    typedef logic [`SCHED_PORT_W-1:0] port_id_t;

    // Packet length in bytes, 1 to 1500
    typedef logic [`SCHED_BLEN_W-1:0] blen_t;

    // Bytes carried by one notification word
    typedef logic [`SCHED_BYTES_W-1:0] word_bytes_t;

    // One bit per queue / per port
    typedef logic [`SCHED_NUM_QUEUES-1:0] queue_mask_t;
    typedef logic [`SCHED_NUM_PORTS-1:0] port_mask_t;

endpackage

`default_nettype wire

// File: blen_fifo.sv
//////////////////////////////
// Packet length FIFO
// Circular buffer of lengths for one queue
//////////////////////////////

`default_nettype none
`timescale 1ns/1ns

`include "sched_consts.svh"

module blen_fifo (
    input  wire logic               core_clk_ifc,
    input  wire logic               arst_n,
    input  wire logic               push,
    input  sched_pkg::blen_t        push_blen,
    input  wire logic               pop,
    output sched_pkg::blen_t        head_blen,
    output logic                    empty,
    output logic                    full
);

    localparam int DEPTH = `SCHED_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    sched_pkg::blen_t   mem [DEPTH];
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W-1:0]   wr_ptr;
    logic [CNT_W-1:0]   count;

    always_ff @(posedge core_clk_ifc) begin
        if (push) begin
            mem[wr_ptr] <= push_blen;
        end
    end

    always_ff @(posedge core_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head_blen = mem[rd_ptr];
    assign empty     = (count == '0);
    assign full      = (count == CNT_W'(DEPTH));

    // Enqueue side and scheduler must respect the fill level
    a_no_push_full: assert property (@(posedge core_clk_ifc) disable iff (!arst_n)
        !(push && full)) else $error("push into full length FIFO");
    a_no_pop_empty: assert property (@(posedge core_clk_ifc) disable iff (!arst_n)
        !(pop && empty)) else $error("pop from empty length FIFO");

endmodule

`default_nettype wire

// File: queue_store.sv
//////////////////////////////
// Queue store
// Length FIFOs, request pipe and dequeue notifications
//////////////////////////////

`default_nettype none
`timescale 1ns/1ns

`include "sched_consts.svh"

module queue_store (
    input  wire logic                 core_clk_ifc,
    input  wire logic                 arst_n,
    input  wire logic                 enq_valid,
    input  sched_pkg::queue_id_t      enq_queue,
    input  sched_pkg::blen_t          enq_blen,
    input  wire logic                 req_valid,
    input  sched_pkg::queue_id_t      req_queue,
    output sched_pkg::queue_mask_t    queue_empty,
    output logic                      note_valid,
    output sched_pkg::queue_id_t      note_queue,
    output sched_pkg::word_bytes_t    note_bytes,
    output logic                      note_last
);

    localparam int NQ    = `SCHED_NUM_QUEUES;
    localparam int STAGES = `SCHED_REQ_PIPE;

    sched_pkg::queue_mask_t push;
    sched_pkg::queue_mask_t pop;
    sched_pkg::blen_t       head_blen [NQ];

    // Bytes still to send of the packet at each queue head
    sched_pkg::blen_t       rem_bytes [NQ];
    sched_pkg::queue_mask_t in_pkt;

    logic [STAGES-1:0]      pipe_valid;
    sched_pkg::queue_id_t   pipe_queue [STAGES];

    logic                   end_valid;
    sched_pkg::queue_id_t   end_queue;
    sched_pkg::blen_t       cur_bytes;
    logic                   end_last;

    //////////////////////////////
    // Per-queue length FIFOs
    //////////////////////////////

    for (genvar q = 0; q < NQ; q++) begin : g_fifo
        assign push[q] = enq_valid && (enq_queue == sched_pkg::queue_id_t'(q));
        assign pop[q]  = end_valid && end_last && (end_queue == sched_pkg::queue_id_t'(q));

        blen_fifo fifo_inst (
            .core_clk_ifc (core_clk_ifc),
            .arst_n       (arst_n),
            .push         (push[q]),
            .push_blen    (enq_blen),
            .pop          (pop[q]),
            .head_blen    (head_blen[q]),
            .empty        (queue_empty[q]),
            .full         ()
        );
    end

    //////////////////////////////
    // Request pipe
    //////////////////////////////

    always_ff @(posedge core_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            pipe_valid <= '0;
        end else begin
            pipe_valid <= {pipe_valid[STAGES-2:0], req_valid};
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        pipe_queue[0] <= req_queue;
        for (int s = 1; s < STAGES; s++) begin
            pipe_queue[s] <= pipe_queue[s-1];
        end
    end

    assign end_valid = pipe_valid[STAGES-1];
    assign end_queue = pipe_queue[STAGES-1];

    // New packet starts from the FIFO head length
    assign cur_bytes = in_pkt[end_queue] ? rem_bytes[end_queue] : head_blen[end_queue];
    assign end_last  = (cur_bytes <= sched_pkg::blen_t'(`SCHED_WORD_BYTES));

    //////////////////////////////
    // Word split and output
    //////////////////////////////

    always_ff @(posedge core_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            in_pkt     <= '0;
            note_valid <= 1'b0;
        end else begin
            note_valid <= end_valid;
            if (end_valid) begin
                in_pkt[end_queue] <= !end_last;
            end
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (end_valid) begin
            note_queue <= end_queue;
            note_last  <= end_last;
            if (end_last) begin
                note_bytes <= sched_pkg::word_bytes_t'(cur_bytes);
            end else begin
                note_bytes <= sched_pkg::word_bytes_t'(`SCHED_WORD_BYTES);
                rem_bytes[end_queue] <= cur_bytes - sched_pkg::blen_t'(`SCHED_WORD_BYTES);
            end
        end
    end

    // A zero-length packet has no word to carry it
    a_blen_nonzero: assert property (@(posedge core_clk_ifc) disable iff (!arst_n)
        enq_valid |-> (enq_blen != '0)) else $error("zero-length packet enqueued");

    // Scheduler never reaches the pipe end with an empty queue
    a_head_present: assert property (@(posedge core_clk_ifc) disable iff (!arst_n)
        end_valid |-> !queue_empty[end_queue]) else $error("dequeue from empty queue");

endmodule

`default_nettype wire

// File: egress_credit.sv
//////////////////////////////
// Egress credits
// One buffer credit counter per port
//////////////////////////////

`default_nettype none
`timescale 1ns/1ns

`include "sched_consts.svh"

module egress_credit (
    input  wire logic                 core_clk_ifc,
    input  wire logic                 arst_n,
    input  wire logic                 req_valid,
    input  sched_pkg::queue_id_t      req_queue,
    input  sched_pkg::port_mask_t     egr_release,
    output sched_pkg::port_mask_t     credit_avail
);

    localparam int CREDIT_W = $clog2(`SCHED_BUF_WORDS + 1);

    sched_pkg::port_id_t req_port;

    assign req_port = req_queue[`SCHED_QUEUE_W-1 -: `SCHED_PORT_W];

    for (genvar p = 0; p < `SCHED_NUM_PORTS; p++) begin : g_port
        logic                take;
        logic [CREDIT_W-1:0] count;

        assign take = req_valid && (req_port == sched_pkg::port_id_t'(p));

        // Request and release together leave the count as is
        always_ff @(posedge core_clk_ifc or negedge arst_n) begin
            if (!arst_n) begin
                count <= CREDIT_W'(`SCHED_BUF_WORDS);
            end else if (take && !egr_release[p]) begin
                count <= count - 1'b1;
            end else if (!take && egr_release[p]) begin
                count <= count + 1'b1;
            end
        end

        assign credit_avail[p] = (count != '0);

        a_no_underflow: assert property (@(posedge core_clk_ifc) disable iff (!arst_n)
            (take && !egr_release[p]) |-> (count != '0))
            else $error("port %0d credit underflow", p);
        a_no_overflow: assert property (@(posedge core_clk_ifc) disable iff (!arst_n)
            (egr_release[p] && !take) |-> (count != CREDIT_W'(`SCHED_BUF_WORDS)))
            else $error("port %0d credit overflow", p);
    end

endmodule

`default_nettype wire

// File: prio_scheduler.sv
//////////////////////////////
// Dequeue scheduler
// Strict priority per port, round robin over ports
//////////////////////////////

`default_nettype none
`timescale 1ns/1ns

`include "sched_consts.svh"

module prio_scheduler (
    input  wire logic                 core_clk_ifc,
    input  wire logic                 arst_n,
    input  sched_pkg::queue_mask_t    queue_empty,
    input  sched_pkg::port_mask_t     credit_avail,
    input  wire logic                 note_valid,
    input  sched_pkg::queue_id_t      note_queue,
    input  wire logic                 note_last,
    output logic                      req_valid,
    output sched_pkg::queue_id_t      req_queue
);

    localparam int NP = `SCHED_NUM_PORTS;
    localparam int NC = `SCHED_CLASSES_PER_PORT;
    localparam int CW = `SCHED_CLASS_W;

    // Per-port state
    sched_pkg::port_mask_t  outstanding;
    sched_pkg::port_mask_t  locked;
    logic [CW-1:0]          lock_class [NP];
    sched_pkg::port_id_t    rr_ptr;

    logic [CW-1:0]          sel_class [NP];
    sched_pkg::port_mask_t  has_work;
    sched_pkg::port_mask_t  eligible;
    logic                   grant_valid;
    sched_pkg::port_id_t    grant_port;
    sched_pkg::port_id_t    note_port;

    assign note_port = note_queue[`SCHED_QUEUE_W-1 -: `SCHED_PORT_W];

    //////////////////////////////
    // Class select per port
    //////////////////////////////

    always_comb begin
        for (int p = 0; p < NP; p++) begin
            sel_class[p] = '0;
            has_work[p]  = 1'b0;
            // Ascending scan, so the highest non-empty class wins
            for (int c = 0; c < NC; c++) begin
                if (!queue_empty[p*NC + c]) begin
                    sel_class[p] = CW'(c);
                    has_work[p]  = 1'b1;
                end
            end
            // Packet in progress keeps its queue
            if (locked[p]) begin
                sel_class[p] = lock_class[p];
                has_work[p]  = 1'b1;
            end
        end
    end

    assign eligible = has_work & credit_avail & ~outstanding;

    //////////////////////////////
    // Round robin over ports
    //////////////////////////////

    always_comb begin
        sched_pkg::port_id_t idx;
        grant_valid = 1'b0;
        grant_port  = rr_ptr;
        // Descending scan, nearest port to the pointer wins
        for (int i = NP - 1; i >= 0; i--) begin
            idx = sched_pkg::port_id_t'(rr_ptr + i);
            if (eligible[idx]) begin
                grant_valid = 1'b1;
                grant_port  = idx;
            end
        end
    end

    always_ff @(posedge core_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            req_valid   <= 1'b0;
            outstanding <= '0;
            locked      <= '0;
            rr_ptr      <= '0;
        end else begin
            req_valid <= grant_valid;
            if (note_valid) begin
                outstanding[note_port] <= 1'b0;
                if (note_last) begin
                    locked[note_port] <= 1'b0;
                end
            end
            if (grant_valid) begin
                outstanding[grant_port] <= 1'b1;
                locked[grant_port]      <= 1'b1;
                rr_ptr                  <= grant_port + 1'b1;
            end
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        req_queue <= {grant_port, sel_class[grant_port]};
        if (grant_valid) begin
            lock_class[grant_port] <= sel_class[grant_port];
        end
    end

    // Every notification answers an earlier request of its port
    a_note_expected: assert property (@(posedge core_clk_ifc) disable iff (!arst_n)
        note_valid |-> outstanding[note_port]) else $error("unexpected notification");

endmodule

`default_nettype wire

// File: sched_top.sv
//////////////////////////////
// Egress packet scheduler top
// Queue store, credits and scheduler
//////////////////////////////

`default_nettype none
`timescale 1ns/1ns

`include "sched_consts.svh"

module sched_top (
    input  wire logic                 core_clk_ifc,
    input  wire logic                 arst_n,
    input  wire logic                 enq_valid,
    input  sched_pkg::queue_id_t      enq_queue,
    input  sched_pkg::blen_t          enq_blen,
    input  sched_pkg::port_mask_t     egr_release,
    output logic                      note_valid,
    output sched_pkg::queue_id_t      note_queue,
    output sched_pkg::word_bytes_t    note_bytes,
    output logic                      note_last
);

    sched_pkg::queue_mask_t queue_empty;
    sched_pkg::port_mask_t  credit_avail;
    logic                   req_valid;
    sched_pkg::queue_id_t   req_queue;

    queue_store queue_store_inst (
        .core_clk_ifc (core_clk_ifc),
        .arst_n       (arst_n),
        .enq_valid    (enq_valid),
        .enq_queue    (enq_queue),
        .enq_blen     (enq_blen),
        .req_valid    (req_valid),
        .req_queue    (req_queue),
        .queue_empty  (queue_empty),
        .note_valid   (note_valid),
        .note_queue   (note_queue),
        .note_bytes   (note_bytes),
        .note_last    (note_last)
    );

    egress_credit egress_credit_inst (
        .core_clk_ifc (core_clk_ifc),
        .arst_n       (arst_n),
        .req_valid    (req_valid),
        .req_queue    (req_queue),
        .egr_release  (egr_release),
        .credit_avail (credit_avail)
    );

    // Notifications feed back to free the port and end the lock
    prio_scheduler prio_scheduler_inst (
        .core_clk_ifc (core_clk_ifc),
        .arst_n       (arst_n),
        .queue_empty  (queue_empty),
        .credit_avail (credit_avail),
        .note_valid   (note_valid),
        .note_queue   (note_queue),
        .note_last    (note_last),
        .req_valid    (req_valid),
        .req_queue    (req_queue)
    );

endmodule

`default_nettype wire

// File: tb_sched.sv
//////////////////////////////
// Egress scheduler testbench
// Reference model, stimulus, checks and timeout
//////////////////////////////

`default_nettype none
`timescale 1ns/1ns

`include "sched_consts.svh"

module tb_sched;

    logic                   core_clk_ifc = 1'b0;
    logic                   arst_n = 1'b0;
    logic                   enq_valid = 1'b0;
    sched_pkg::queue_id_t   enq_queue = '0;
    sched_pkg::blen_t       enq_blen = '0;
    sched_pkg::port_mask_t  egr_release = '0;
    logic                   note_valid;
    sched_pkg::queue_id_t   note_queue;
    sched_pkg::word_bytes_t note_bytes;
    logic                   note_last;

    // Stimulus side, written by the test sequence only
    int          sent_len [`SCHED_NUM_QUEUES][$];
    int          c3_enq [`SCHED_NUM_PORTS];
    int          total_words;
    int          test_errors;
    int          tests_passed;
    int          tests_failed;
    int          errors_before;
    bit          hold_release;
    logic [31:0] rng_state = 32'h6a2c8720;

    // Monitor side
    int done_cnt [`SCHED_NUM_QUEUES];
    int word_idx [`SCHED_NUM_QUEUES];
    int byte_sum [`SCHED_NUM_QUEUES];
    int owed [`SCHED_NUM_PORTS];
    int port_words [`SCHED_NUM_PORTS];
    int lock_queue [`SCHED_NUM_PORTS];
    bit port_busy [`SCHED_NUM_PORTS];
    int c3_done [`SCHED_NUM_PORTS];
    int mon_errors;
    int cycles;

    sched_top sched_top_inst (
        .core_clk_ifc (core_clk_ifc),
        .arst_n       (arst_n),
        .enq_valid    (enq_valid),
        .enq_queue    (enq_queue),
        .enq_blen     (enq_blen),
        .egr_release  (egr_release),
        .note_valid   (note_valid),
        .note_queue   (note_queue),
        .note_bytes   (note_bytes),
        .note_last    (note_last)
    );

    always #5 core_clk_ifc = ~core_clk_ifc;

    function logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Expected bytes and last flag of word idx of a packet
    function automatic void expected_word(input int len, input int idx,
                                          output int bytes, output bit last);
        int remain;
        remain = len - idx * `SCHED_WORD_BYTES;
        if (remain > `SCHED_WORD_BYTES) begin
            bytes = `SCHED_WORD_BYTES;
            last  = 1'b0;
        end else begin
            bytes = remain;
            last  = 1'b1;
        end
    endfunction

    //////////////////////////////
    // Notification checks
    //////////////////////////////

    always @(negedge core_clk_ifc) begin
        int q;
        int p;
        int exp_bytes;
        int len;
        bit exp_last;
        if (arst_n && note_valid) begin
            q = int'(note_queue);
            p = q / `SCHED_CLASSES_PER_PORT;
            port_words[p]++;
            owed[p]++;
            if (done_cnt[q] >= sent_len[q].size()) begin
                $display("Notification on queue %0d with no packet queued", q);
                mon_errors++;
            end else begin
                len = sent_len[q][done_cnt[q]];
                expected_word(len, word_idx[q], exp_bytes, exp_last);
                if (int'(note_bytes) != exp_bytes) begin
                    $display("Error: note_bytes on queue %0d got %h expected %h",
                             q, note_bytes, exp_bytes);
                    mon_errors++;
                end
                if (note_last !== exp_last) begin
                    $display("Error: note_last on queue %0d got %h expected %h",
                             q, note_last, exp_last);
                    mon_errors++;
                end
                // Packet lock keeps the port on one queue
                if (port_busy[p] && lock_queue[p] != q) begin
                    $display("Error: note_queue on port %0d got %h expected %h",
                             p, note_queue, lock_queue[p]);
                    mon_errors++;
                end
                if (q % `SCHED_CLASSES_PER_PORT == 0 && c3_done[p] < c3_enq[p]) begin
                    $display("Class 0 word on port %0d before its class 3 packets ended", p);
                    mon_errors++;
                end
                byte_sum[q] += int'(note_bytes);
                word_idx[q]++;
                if (exp_last) begin
                    if (byte_sum[q] != len) begin
                        $display("Error: byte sum on queue %0d got %h expected %h",
                                 q, byte_sum[q], len);
                        mon_errors++;
                    end
                    if (q % `SCHED_CLASSES_PER_PORT == 3) begin
                        c3_done[p]++;
                    end
                    done_cnt[q]++;
                    word_idx[q]  = 0;
                    byte_sum[q]  = 0;
                    port_busy[p] = 1'b0;
                end else begin
                    port_busy[p]  = 1'b1;
                    lock_queue[p] = q;
                end
            end
        end
        // Return one credit per word unless held back
        for (int i = 0; i < `SCHED_NUM_PORTS; i++) begin
            egr_release[i] = !hold_release && owed[i] > 0;
            if (egr_release[i]) begin
                owed[i]--;
            end
        end
    end

    // Run limit grows with the words enqueued so far
    always @(posedge core_clk_ifc) begin
        cycles++;
        if (cycles > 4 * total_words + 2000) begin
            $display("Timeout: run exceeded %0d cycles", cycles);
            $display("Test failures found");
            $finish;
        end
    end

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////

    task automatic enqueue(input int q, input int len);
        while (sent_len[q].size() - done_cnt[q] >= `SCHED_FIFO_DEPTH) begin
            @(negedge core_clk_ifc);
        end
        enq_valid = 1'b1;
        enq_queue = sched_pkg::queue_id_t'(q);
        enq_blen  = sched_pkg::blen_t'(len);
        sent_len[q].push_back(len);
        total_words += (len + `SCHED_WORD_BYTES - 1) / `SCHED_WORD_BYTES;
        @(negedge core_clk_ifc);
        enq_valid = 1'b0;
    endtask

    task automatic wait_idle();
        bit busy;
        busy = 1'b1;
        while (busy) begin
            @(negedge core_clk_ifc);
            busy = 1'b0;
            for (int q = 0; q < `SCHED_NUM_QUEUES; q++) begin
                if (done_cnt[q] != sent_len[q].size()) busy = 1'b1;
            end
            for (int p = 0; p < `SCHED_NUM_PORTS; p++) begin
                if (owed[p] != 0) busy = 1'b1;
            end
        end
        repeat (2) @(negedge core_clk_ifc);
    endtask

    task automatic report_test(input int num, input string name);
        int errs;
        errs = mon_errors + test_errors - errors_before;
        if (errs == 0) begin
            tests_passed++;
            $display("Test %0d %s: PASS", num, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: FAIL with %0d errors", num, name, errs);
        end
        errors_before = mon_errors + test_errors;
    endtask

    function automatic int random_len(input int span);
        return 1 + int'((next_rand() >> 8) % span);
    endfunction

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        int base [`SCHED_NUM_PORTS];
        int directed [8];
        directed = '{1, 63, 64, 65, 128, 129, 1500, 700};
        repeat (10) @(posedge core_clk_ifc);
        @(negedge core_clk_ifc);
        arst_n = 1'b1;

        // 1: idle after reset
        repeat (20) begin
            @(negedge core_clk_ifc);
            if (note_valid !== 1'b0) begin
                $display("Error: note_valid got %h expected %h", note_valid, 1'b0);
                test_errors++;
            end
        end
        report_test(1, "reset");

        // 2: boundary lengths spread over all ports
        for (int i = 0; i < 8; i++) begin
            enqueue((i % 4) * 4 + i / 4, directed[i]);
        end
        wait_idle();
        report_test(2, "word splitting");

        // 3: three classes of port 1 compete
        for (int i = 0; i < 4; i++) begin
            enqueue(5, random_len(300));
            enqueue(6, random_len(300));
            enqueue(4, random_len(300));
        end
        wait_idle();
        report_test(3, "order and lock");

        // 4: class 3 enqueued ahead of class 0 on every port
        for (int p = 0; p < `SCHED_NUM_PORTS; p++) begin
            c3_enq[p] = c3_done[p] + 2;
        end
        for (int i = 0; i < 8; i++) begin
            enqueue((i % 4) * 4 + 3, 100 + random_len(400));
        end
        for (int i = 0; i < 8; i++) begin
            enqueue((i % 4) * 4, random_len(400));
        end
        wait_idle();
        report_test(4, "strict priority");

        // 5: credits withheld, then returned
        hold_release = 1'b1;
        for (int p = 0; p < `SCHED_NUM_PORTS; p++) begin
            base[p] = port_words[p];
        end
        for (int p = 0; p < `SCHED_NUM_PORTS; p++) begin
            enqueue(p * 4 + 1, 400 + random_len(1100));
        end
        for (int p = 0; p < `SCHED_NUM_PORTS; p++) begin
            while (port_words[p] - base[p] < `SCHED_BUF_WORDS) begin
                @(negedge core_clk_ifc);
            end
        end
        repeat (40) @(negedge core_clk_ifc);
        for (int p = 0; p < `SCHED_NUM_PORTS; p++) begin
            if (port_words[p] - base[p] != `SCHED_BUF_WORDS) begin
                $display("Error: port %0d word count got %h expected %h",
                         p, port_words[p] - base[p], `SCHED_BUF_WORDS);
                test_errors++;
            end
        end
        hold_release = 1'b0;
        wait_idle();
        report_test(5, "back-pressure");

        // 6: random queues and lengths
        for (int i = 0; i < 40; i++) begin
            enqueue(int'(next_rand() >> 12) % `SCHED_NUM_QUEUES, random_len(1500));
        end
        wait_idle();
        report_test(6, "random mix");

        $display("Summary: %0d passed, %0d failed, %0d errors",
                 tests_passed, tests_failed, mon_errors + test_errors);
        if (tests_failed == 0 && mon_errors + test_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+.
sched_pkg.sv
blen_fifo.sv
queue_store.sv
egress_credit.sv
prio_scheduler.sv
sched_top.sv
tb_sched.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the egress scheduler testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_sched -o tb_sched_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_sched_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q "All tests passed!"; then
    exit 0
fi
exit 1
